/* src.f */
design/csr_pkg.sv
design/csr_exception.sv
design/csr_timer.sv
design/csr_scratch.sv
design/csr_file.sv
tb/tb_csr_file.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_csr_file
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

/* tb/tb_csr_file.sv */
`timescale 1ns/1ps

module tb_csr_file;

    localparam int SAVE_COUNT   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int N_INIT       = 10;
    localparam int N_RANDOM     = 40;
    localparam int N_EXC        = 4;
    localparam int L_ONESHOT    = 5;
    localparam int L_PERIODIC   = 3;
    localparam int PERIOD       = 4 * L_PERIODIC + 1;
    // Sum of all test phases in clock cycles, with some slack
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 * (N_INIT + N_RANDOM) + 14 * N_EXC
                                + 2 * (4 * L_ONESHOT + 8) + 6 * PERIOD + 40;

    localparam logic [csr_pkg::CSR_NUM_W-1:0] RW_NUMS [N_INIT] = '{
        csr_pkg::CSR_EENTRY, csr_pkg::CSR_SAVE_BASE, csr_pkg::CSR_SAVE_BASE + 14'd1,
        csr_pkg::CSR_SAVE_BASE + 14'd2, csr_pkg::CSR_SAVE_BASE + 14'd3, csr_pkg::CSR_ERA,
        csr_pkg::CSR_ECFG, csr_pkg::CSR_TID, csr_pkg::CSR_PRMD, csr_pkg::CSR_BADV
    };
    localparam logic [5:0] EX_CODES [N_EXC] = '{
        csr_pkg::ECODE_ADE, csr_pkg::ECODE_ALE, csr_pkg::ECODE_ADE, 6'h0b
    };
    localparam logic [8:0] EX_SUBS [N_EXC] = '{csr_pkg::ESUBCODE_ADEF, 9'h000, 9'h001, 9'h000};

    logic        clk;
    logic        reset;
    logic        csr_we;
    logic [13:0] csr_num;
    logic [31:0] csr_wmask;
    logic [31:0] csr_wvalue;
    logic        wb_ex;
    logic [5:0]  wb_ecode;
    logic [8:0]  wb_esubcode;
    logic [31:0] wb_pc;
    logic [31:0] wb_vaddr;
    logic        ertn_flush;
    logic [31:0] csr_rvalue;
    logic [31:0] ex_entry;
    logic [31:0] ertn_entry;
    logic        has_int;
    logic [1:0]  crmd_plv;
    logic        crmd_da;
    logic        crmd_pg;

    // Shadow model of the register file
    logic [31:0] m_crmd;
    logic [31:0] m_prmd;
    logic [31:0] m_ecfg;
    logic [31:0] m_is_sw;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [31:0] m_eentry;
    logic [31:0] m_tid;
    logic [31:0] m_tcfg;
    logic [31:0] m_save [SAVE_COUNT];
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    bit          timer_loaded;
    int          t_load;
    int          t_clear;
    int          cyc = 0;
    bit          read_req;
    int          err_count = 0;

    csr_file #(
        .SAVE_COUNT (SAVE_COUNT)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .csr_we      (csr_we),
        .csr_num     (csr_num),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .ertn_flush  (ertn_flush),
        .csr_rvalue  (csr_rvalue),
        .ex_entry    (ex_entry),
        .ertn_entry  (ertn_entry),
        .has_int     (has_int),
        .crmd_plv    (crmd_plv),
        .crmd_da     (crmd_da),
        .crmd_pg     (crmd_pg)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    ////////////////////
    // Reference model

    function automatic logic [31:0] masked(input logic [31:0] old, input logic [31:0] mask,
                                           input logic [31:0] value);
        return old & ~mask | value & mask;
    endfunction

    // Countdown value from the load edge and elapsed edges
    function automatic logic [31:0] timer_value();
        int n;
        int top;
        n   = cyc - t_load;
        top = 4 * int'(m_tcfg[31:2]);
        if (!timer_loaded) return '1;
        if (m_tcfg[1]) return 32'(top - n % (top + 1));
        return (n <= top) ? 32'(top - n) : '1;
    endfunction

    function automatic bit timer_pending();
        int n;
        int period;
        int last_exp;
        n      = cyc - t_load;
        period = 4 * int'(m_tcfg[31:2]) + 1;
        if (!timer_loaded || n < period) return 1'b0;
        last_exp = t_load + (m_tcfg[1] ? (n / period) * period : period);
        // Expiry at the clear edge wins
        return last_exp >= t_clear;
    endfunction

    function automatic logic [31:0] status_is();
        return m_is_sw | (timer_pending() ? 32'h800 : 32'h0);
    endfunction

    function automatic bit expect_int();
        return (|(status_is() & m_ecfg & 32'hfff)) && m_crmd[2];
    endfunction

    function automatic logic [31:0] expect_read(input logic [13:0] num);
        int k;
        k = int'(num) - int'(csr_pkg::CSR_SAVE_BASE);
        case (num)
            csr_pkg::CSR_CRMD:   return m_crmd;
            csr_pkg::CSR_PRMD:   return m_prmd;
            csr_pkg::CSR_ECFG:   return m_ecfg;
            csr_pkg::CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 16'h0} | status_is();
            csr_pkg::CSR_ERA:    return m_era;
            csr_pkg::CSR_BADV:   return m_badv;
            csr_pkg::CSR_EENTRY: return m_eentry;
            csr_pkg::CSR_TID:    return m_tid;
            csr_pkg::CSR_TCFG:   return m_tcfg;
            csr_pkg::CSR_TVAL:   return timer_value();
            default:             return (k >= 0 && k < SAVE_COUNT) ? m_save[k] : '0;
        endcase
    endfunction

    task automatic model_write(input logic [13:0] num, input logic [31:0] mask,
                               input logic [31:0] value);
        int k;
        k = int'(num) - int'(csr_pkg::CSR_SAVE_BASE);
        case (num)
            csr_pkg::CSR_CRMD:   m_crmd   = masked(m_crmd, mask, value) & 32'h1f;
            csr_pkg::CSR_PRMD:   m_prmd   = masked(m_prmd, mask, value) & 32'h7;
            csr_pkg::CSR_ECFG:   m_ecfg   = masked(m_ecfg, mask, value) & 32'h1bff;
            csr_pkg::CSR_ESTAT:  m_is_sw  = masked(m_is_sw, mask, value) & 32'h3;
            csr_pkg::CSR_ERA:    m_era    = masked(m_era, mask, value);
            csr_pkg::CSR_BADV:   m_badv   = masked(m_badv, mask, value);
            csr_pkg::CSR_EENTRY: m_eentry = masked(m_eentry, mask, value) & 32'hffff_ffc0;
            csr_pkg::CSR_TID:    m_tid    = masked(m_tid, mask, value);
            csr_pkg::CSR_TCFG: begin
                m_tcfg = masked(m_tcfg, mask, value);
                if (m_tcfg[0]) begin
                    timer_loaded = 1'b1;
                    t_load       = cyc + 1;
                end
            end
            csr_pkg::CSR_TICLR: begin
                if (mask[0] && value[0]) t_clear = cyc + 1;
            end
            default: begin
                if (k >= 0 && k < SAVE_COUNT) m_save[k] = masked(m_save[k], mask, value);
            end
        endcase
    endtask

    ////////////////////
    // Stimulus

    task automatic idle_inputs();
        csr_we     = 1'b0;
        wb_ex      = 1'b0;
        ertn_flush = 1'b0;
        read_req   = 1'b0;
    endtask

    task automatic write_csr(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] value);
        @(posedge clk);
        #1;
        idle_inputs();
        csr_we     = 1'b1;
        csr_num    = num;
        csr_wmask  = mask;
        csr_wvalue = value;
        model_write(num, mask, value);
    endtask

    task automatic read_csr(input logic [13:0] num);
        @(posedge clk);
        #1;
        idle_inputs();
        csr_num  = num;
        read_req = 1'b1;
    endtask

    task automatic raise_ex(input logic [5:0] ecode, input logic [8:0] esub,
                            input logic [31:0] pc, input logic [31:0] vaddr);
        @(posedge clk);
        #1;
        idle_inputs();
        wb_ex       = 1'b1;
        wb_ecode    = ecode;
        wb_esubcode = esub;
        wb_pc       = pc;
        wb_vaddr    = vaddr;
        m_prmd      = m_crmd & 32'h7;
        m_crmd      = m_crmd & ~32'h7;
        m_ecode     = ecode;
        m_esub      = esub;
        m_era       = pc;
        if (ecode == csr_pkg::ECODE_ADE || ecode == csr_pkg::ECODE_ALE) begin
            m_badv = (ecode == csr_pkg::ECODE_ADE && esub == csr_pkg::ESUBCODE_ADEF) ? pc : vaddr;
        end
    endtask

    task automatic return_ex();
        @(posedge clk);
        #1;
        idle_inputs();
        ertn_flush = 1'b1;
        m_crmd     = m_crmd & ~32'h7 | m_prmd & 32'h7;
    endtask

    task automatic read_exception_regs();
        read_csr(csr_pkg::CSR_CRMD);
        read_csr(csr_pkg::CSR_PRMD);
        read_csr(csr_pkg::CSR_ESTAT);
        read_csr(csr_pkg::CSR_ERA);
        read_csr(csr_pkg::CSR_BADV);
        read_csr(csr_pkg::CSR_EENTRY);
    endtask

    task automatic report_mismatch(input string what, input logic [13:0] num,
                                   input logic [31:0] got, input logic [31:0] exp);
        err_count++;
        $display("Error: time %0t csr 0x%03h %s got 0x%08h expected 0x%08h",
                 $time, num, what, got, exp);
        $display("Result: FAILED");
        $fatal(1, "stopping at first mismatch");
    endtask

    // Outputs are stable by the falling edge
    initial begin : compare
        logic [31:0] exp_rd;
        bit          exp_int;
        forever begin
            @(negedge clk);
            if (read_req) begin
                exp_rd  = expect_read(csr_num);
                exp_int = expect_int();
                assert (csr_rvalue === exp_rd) else
                    report_mismatch("csr_rvalue", csr_num, csr_rvalue, exp_rd);
                assert (has_int === exp_int) else
                    report_mismatch("has_int", csr_num, {31'b0, has_int}, {31'b0, exp_int});
                assert (ex_entry === m_eentry) else
                    report_mismatch("ex_entry", csr_num, ex_entry, m_eentry);
                assert (ertn_entry === m_era) else
                    report_mismatch("ertn_entry", csr_num, ertn_entry, m_era);
                assert (crmd_plv === m_crmd[1:0]) else
                    report_mismatch("crmd_plv", csr_num, {30'b0, crmd_plv},
                                    {30'b0, m_crmd[1:0]});
                assert (crmd_da === m_crmd[3]) else
                    report_mismatch("crmd_da", csr_num, {31'b0, crmd_da}, {31'b0, m_crmd[3]});
                assert (crmd_pg === m_crmd[4]) else
                    report_mismatch("crmd_pg", csr_num, {31'b0, crmd_pg}, {31'b0, m_crmd[4]});
            end
        end
    end

    initial begin : watchdog
        #(TEST_CYCLES * 2 * 10);
        $display("Timeout: the tests did not finish within the expected run time");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        int idx;
        reset       = 1'b1;
        csr_num     = '0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        idle_inputs();
        void'($urandom(7235));
        m_crmd       = 32'h8;
        m_ecfg       = '0;
        m_is_sw      = '0;
        m_tid        = '0;
        m_tcfg       = '0;
        timer_loaded = 1'b0;
        t_load       = 0;
        t_clear      = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // ESTAT code fields have no reset value
        raise_ex(6'h00, 9'h000, $urandom(), $urandom());
        for (int i = 0; i < N_INIT; i++) write_csr(RW_NUMS[i], '1, $urandom());
        for (int i = 0; i < N_INIT; i++) read_csr(RW_NUMS[i]);
        for (int i = 0; i < N_RANDOM; i++) begin
            idx = int'($urandom() % N_INIT);
            write_csr(RW_NUMS[idx], $urandom(), $urandom());
            read_csr(RW_NUMS[idx]);
        end
        read_csr(14'h0002);
        read_csr(csr_pkg::CSR_SAVE_BASE + 14'(SAVE_COUNT));
        read_csr(14'h1abc);
        read_csr(csr_pkg::CSR_TICLR);
        read_csr(csr_pkg::CSR_CRMD);

        ////////////////////
        // Exception entry and return
        for (int i = 0; i < N_EXC; i++) begin
            write_csr(csr_pkg::CSR_CRMD, 32'h1f,
                      {27'b0, 2'($urandom()), 1'b1, 2'(1 + $urandom() % 3)});
            raise_ex(EX_CODES[i], EX_SUBS[i], $urandom(), $urandom());
            read_exception_regs();
            return_ex();
            read_csr(csr_pkg::CSR_CRMD);
        end

        ////////////////////
        // Timer
        write_csr(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        write_csr(csr_pkg::CSR_TCFG, '1, {30'(L_ONESHOT), 2'b01});
        repeat (4 * L_ONESHOT + 4) read_csr(csr_pkg::CSR_TVAL);
        read_csr(csr_pkg::CSR_TCFG);
        write_csr(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        read_csr(csr_pkg::CSR_ESTAT);
        read_csr(csr_pkg::CSR_TVAL);
        write_csr(csr_pkg::CSR_TCFG, '1, {30'(L_ONESHOT), 2'b01});
        repeat (4 * L_ONESHOT + 4) read_csr(csr_pkg::CSR_ESTAT);

        // Periodic mode, with the interrupt gated by LIE and IE
        write_csr(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        write_csr(csr_pkg::CSR_ECFG, 32'h1fff, 32'h800);
        write_csr(csr_pkg::CSR_CRMD, 32'h4, 32'h0);
        write_csr(csr_pkg::CSR_TCFG, '1, {30'(L_PERIODIC), 2'b11});
        repeat (2 * PERIOD) read_csr(csr_pkg::CSR_ESTAT);
        write_csr(csr_pkg::CSR_CRMD, 32'h4, 32'h4);
        repeat (PERIOD) read_csr(csr_pkg::CSR_ESTAT);
        write_csr(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        repeat (PERIOD + 2) read_csr(csr_pkg::CSR_TVAL);
        write_csr(csr_pkg::CSR_ECFG, 32'h1fff, 32'h001);
        repeat (PERIOD) read_csr(csr_pkg::CSR_ESTAT);
        write_csr(csr_pkg::CSR_ESTAT, 32'h1, 32'h1);
        read_csr(csr_pkg::CSR_ESTAT);
        write_csr(csr_pkg::CSR_ESTAT, 32'h3, 32'h0);
        read_csr(csr_pkg::CSR_ESTAT);

        @(posedge clk);
        #1;
        idle_inputs();
        @(posedge clk);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* design/csr_file.sv */
`timescale 1ns/1ps

module csr_file #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              csr_we,
    input  logic [csr_pkg::CSR_NUM_W-1:0]     csr_num,
    input  logic [csr_pkg::CSR_W-1:0]         csr_wmask,
    input  logic [csr_pkg::CSR_W-1:0]         csr_wvalue,
    input  logic                              wb_ex,
    input  logic [csr_pkg::ECODE_W-1:0]       wb_ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0]    wb_esubcode,
    input  logic [csr_pkg::CSR_W-1:0]         wb_pc,
    input  logic [csr_pkg::CSR_W-1:0]         wb_vaddr,
    input  logic                              ertn_flush,
    output logic [csr_pkg::CSR_W-1:0]         csr_rvalue,
    output logic [csr_pkg::CSR_W-1:0]         ex_entry,
    output logic [csr_pkg::CSR_W-1:0]         ertn_entry,
    output logic                              has_int,
    output logic [1:0]                        crmd_plv,
    output logic                              crmd_da,
    output logic                              crmd_pg
);

    logic [csr_pkg::CSR_W-1:0] ex_rdata;
    logic [csr_pkg::CSR_W-1:0] timer_rdata;
    logic [csr_pkg::CSR_W-1:0] save_rdata;
    logic                      timer_int;

    csr_exception u_exception (
        .clk         (clk),
        .reset       (reset),
        .csr_we      (csr_we),
        .csr_num     (csr_num),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .ertn_flush  (ertn_flush),
        .timer_int   (timer_int),
        .rdata       (ex_rdata),
        .ex_entry    (ex_entry),
        .ertn_entry  (ertn_entry),
        .has_int     (has_int),
        .crmd_plv    (crmd_plv),
        .crmd_da     (crmd_da),
        .crmd_pg     (crmd_pg)
    );

    csr_timer u_timer (
        .clk        (clk),
        .reset      (reset),
        .csr_we     (csr_we),
        .csr_num    (csr_num),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .rdata      (timer_rdata),
        .timer_int  (timer_int)
    );

    csr_scratch #(
        .SAVE_COUNT (SAVE_COUNT)
    ) u_scratch (
        .clk        (clk),
        .csr_we     (csr_we),
        .csr_num    (csr_num),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .rdata      (save_rdata)
    );

    // Blocks return zero for numbers they do not own
    assign csr_rvalue = ex_rdata | timer_rdata | save_rdata;

endmodule

/* design/csr_scratch.sv */
`timescale 1ns/1ps

module csr_scratch #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                          clk,
    input  logic                          csr_we,
    input  logic [csr_pkg::CSR_NUM_W-1:0] csr_num,
    input  logic [csr_pkg::CSR_W-1:0]     csr_wmask,
    input  logic [csr_pkg::CSR_W-1:0]     csr_wvalue,
    output logic [csr_pkg::CSR_W-1:0]     rdata
);

    localparam int NUM_W = csr_pkg::CSR_NUM_W;

    logic [csr_pkg::CSR_W-1:0] save_q   [SAVE_COUNT];
    logic [csr_pkg::CSR_W-1:0] save_sel [SAVE_COUNT];

    for (genvar k = 0; k < SAVE_COUNT; k++) begin : g_save
        localparam logic [NUM_W-1:0] SAVE_NUM = csr_pkg::CSR_SAVE_BASE + NUM_W'(k);

        always_ff @(posedge clk) begin
            if (csr_we && csr_num == SAVE_NUM) begin
                save_q[k] <= csr_wmask & csr_wvalue | ~csr_wmask & save_q[k];
            end
        end

        // Zero unless this entry is addressed
        assign save_sel[k] = (csr_num == SAVE_NUM) ? save_q[k] : '0;
    end

    always_comb begin
        rdata = '0;
        for (int k = 0; k < SAVE_COUNT; k++) begin
            rdata = rdata | save_sel[k];
        end
    end

endmodule

/* design/csr_timer.sv */
`timescale 1ns/1ps

module csr_timer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          csr_we,
    input  logic [csr_pkg::CSR_NUM_W-1:0] csr_num,
    input  logic [csr_pkg::CSR_W-1:0]     csr_wmask,
    input  logic [csr_pkg::CSR_W-1:0]     csr_wvalue,
    output logic [csr_pkg::CSR_W-1:0]     rdata,
    output logic                          timer_int
);

    logic [csr_pkg::CSR_W-1:0] tid;
    logic                      tcfg_en;
    logic                      tcfg_periodic;
    logic [csr_pkg::CSR_W-3:0] tcfg_initval;
    logic [csr_pkg::CSR_W-1:0] tcfg_data;
    logic [csr_pkg::CSR_W-1:0] tcfg_next;
    logic [csr_pkg::CSR_W-1:0] timer_cnt;
    logic                      tcfg_wr;
    logic                      ticlr_hit;

    assign tcfg_wr   = csr_we && csr_num == csr_pkg::CSR_TCFG;
    assign tcfg_data = {tcfg_initval, tcfg_periodic, tcfg_en};
    // TCFG as it will be after this write
    assign tcfg_next = csr_wmask & csr_wvalue | ~csr_wmask & tcfg_data;
    assign ticlr_hit = csr_we && csr_num == csr_pkg::CSR_TICLR && csr_wmask[0] && csr_wvalue[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            tid <= '0;
        end else if (csr_we && csr_num == csr_pkg::CSR_TID) begin
            tid <= csr_wmask & csr_wvalue | ~csr_wmask & tid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en <= 1'b0;
        end else if (tcfg_wr) begin
            tcfg_en <= tcfg_next[0];
        end
    end

    always_ff @(posedge clk) begin
        if (tcfg_wr) begin
            tcfg_periodic <= tcfg_next[1];
            tcfg_initval  <= tcfg_next[csr_pkg::CSR_W-1:2];
        end
    end

    ////////////////////
    // Countdown

    // One-shot mode underflows into the idle value and stops there
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= csr_pkg::TIMER_IDLE;
        end else if (tcfg_wr && tcfg_next[0]) begin
            timer_cnt <= {tcfg_next[csr_pkg::CSR_W-1:2], 2'b0};
        end else if (tcfg_en && timer_cnt != csr_pkg::TIMER_IDLE) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b0};
            end else begin
                timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    // Expiry beats a TICLR clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (timer_cnt == '0) begin
            timer_int <= 1'b1;
        end else if (ticlr_hit) begin
            timer_int <= 1'b0;
        end
    end

    always_comb begin
        case (csr_num)
            csr_pkg::CSR_TID:  rdata = tid;
            csr_pkg::CSR_TCFG: rdata = tcfg_data;
            csr_pkg::CSR_TVAL: rdata = timer_cnt;
            default:           rdata = '0;
        endcase
    end

endmodule

/* design/csr_exception.sv */
`timescale 1ns/1ps

module csr_exception (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              csr_we,
    input  logic [csr_pkg::CSR_NUM_W-1:0]     csr_num,
    input  logic [csr_pkg::CSR_W-1:0]         csr_wmask,
    input  logic [csr_pkg::CSR_W-1:0]         csr_wvalue,
    input  logic                              wb_ex,
    input  logic [csr_pkg::ECODE_W-1:0]       wb_ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0]    wb_esubcode,
    input  logic [csr_pkg::CSR_W-1:0]         wb_pc,
    input  logic [csr_pkg::CSR_W-1:0]         wb_vaddr,
    input  logic                              ertn_flush,
    input  logic                              timer_int,
    output logic [csr_pkg::CSR_W-1:0]         rdata,
    output logic [csr_pkg::CSR_W-1:0]         ex_entry,
    output logic [csr_pkg::CSR_W-1:0]         ertn_entry,
    output logic                              has_int,
    output logic [1:0]                        crmd_plv,
    output logic                              crmd_da,
    output logic                              crmd_pg
);

    logic                                          crmd_ie;
    logic [1:0]                                    prmd_pplv;
    logic                                          prmd_pie;
    logic [csr_pkg::INT_W-1:0]                     ecfg_lie;
    logic [1:0]                                    estat_is_sw;
    logic [csr_pkg::INT_W-1:0]                     estat_is;
    logic [csr_pkg::ECODE_W-1:0]                   estat_ecode;
    logic [csr_pkg::ESUBCODE_W-1:0]                estat_esubcode;
    logic [csr_pkg::CSR_W-1:0]                     era;
    logic [csr_pkg::CSR_W-1:csr_pkg::ENTRY_ALIGN]  eentry_va;
    logic [csr_pkg::CSR_W-1:0]                     badv;
    logic [csr_pkg::CSR_W-1:0]                     eentry_data;
    logic                                          addr_err;

    ////////////////////
    // CRMD and PRMD

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
            crmd_da  <= 1'b1;
            crmd_pg  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_num == csr_pkg::CSR_CRMD) begin
            crmd_plv <= csr_wmask[1:0] & csr_wvalue[1:0] | ~csr_wmask[1:0] & crmd_plv;
            crmd_ie  <= csr_wmask[2] & csr_wvalue[2] | ~csr_wmask[2] & crmd_ie;
            crmd_da  <= csr_wmask[3] & csr_wvalue[3] | ~csr_wmask[3] & crmd_da;
            crmd_pg  <= csr_wmask[4] & csr_wvalue[4] | ~csr_wmask[4] & crmd_pg;
        end
    end

    // Saved mode on exception entry
    always_ff @(posedge clk) begin
        if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_we && csr_num == csr_pkg::CSR_PRMD) begin
            prmd_pplv <= csr_wmask[1:0] & csr_wvalue[1:0] | ~csr_wmask[1:0] & prmd_pplv;
            prmd_pie  <= csr_wmask[2] & csr_wvalue[2] | ~csr_wmask[2] & prmd_pie;
        end
    end

    ////////////////////
    // ECFG and ESTAT

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie    <= '0;
            estat_is_sw <= 2'b0;
        end else if (csr_we && csr_num == csr_pkg::CSR_ECFG) begin
            ecfg_lie <= csr_wmask[csr_pkg::INT_W-1:0] & csr_wvalue[csr_pkg::INT_W-1:0]
                      | ~csr_wmask[csr_pkg::INT_W-1:0] & ecfg_lie;
        end else if (csr_we && csr_num == csr_pkg::CSR_ESTAT) begin
            estat_is_sw <= csr_wmask[1:0] & csr_wvalue[1:0] | ~csr_wmask[1:0] & estat_is_sw;
        end
    end

    // Software bits, plus the timer line
    always_comb begin
        estat_is                         = '0;
        estat_is[1:0]                    = estat_is_sw;
        estat_is[csr_pkg::TIMER_INT_BIT] = timer_int;
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end
    end

    ////////////////////
    // ERA, EENTRY, BADV

    assign addr_err = wb_ecode == csr_pkg::ECODE_ADE || wb_ecode == csr_pkg::ECODE_ALE;

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            era <= wb_pc;
        end else if (csr_we && csr_num == csr_pkg::CSR_ERA) begin
            era <= csr_wmask & csr_wvalue | ~csr_wmask & era;
        end
        if (csr_we && csr_num == csr_pkg::CSR_EENTRY) begin
            eentry_va <= csr_wmask[csr_pkg::CSR_W-1:csr_pkg::ENTRY_ALIGN]
                       & csr_wvalue[csr_pkg::CSR_W-1:csr_pkg::ENTRY_ALIGN]
                       | ~csr_wmask[csr_pkg::CSR_W-1:csr_pkg::ENTRY_ALIGN] & eentry_va;
        end
        // Fetch faults record the PC
        if (wb_ex && addr_err) begin
            badv <= (wb_ecode == csr_pkg::ECODE_ADE && wb_esubcode == csr_pkg::ESUBCODE_ADEF)
                  ? wb_pc : wb_vaddr;
        end else if (csr_we && csr_num == csr_pkg::CSR_BADV) begin
            badv <= csr_wmask & csr_wvalue | ~csr_wmask & badv;
        end
    end

    assign eentry_data = {eentry_va, {csr_pkg::ENTRY_ALIGN{1'b0}}};
    assign ex_entry    = eentry_data;
    assign ertn_entry  = era;
    assign has_int     = (|(estat_is[csr_pkg::TIMER_INT_BIT:0]
                          & ecfg_lie[csr_pkg::TIMER_INT_BIT:0])) & crmd_ie;

    always_comb begin
        case (csr_num)
            csr_pkg::CSR_CRMD:   rdata = {27'b0, crmd_pg, crmd_da, crmd_ie, crmd_plv};
            csr_pkg::CSR_PRMD:   rdata = {29'b0, prmd_pie, prmd_pplv};
            csr_pkg::CSR_ECFG:   rdata = {19'b0, ecfg_lie[12:11], 1'b0, ecfg_lie[9:0]};
            csr_pkg::CSR_ESTAT:  rdata = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
            csr_pkg::CSR_ERA:    rdata = era;
            csr_pkg::CSR_BADV:   rdata = badv;
            csr_pkg::CSR_EENTRY: rdata = eentry_data;
            default:             rdata = '0;
        endcase
    end

endmodule

/* design/csr_pkg.sv */
package csr_pkg;

    ////////////////////
    // Widths

    localparam int CSR_NUM_W  = 14;
    localparam int CSR_W      = 32;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam int INT_W      = 13;

    ////////////////////
    // CSR numbers

    localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h0000;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h0001;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG   = 14'h0004;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h0005;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h0006;
    localparam logic [CSR_NUM_W-1:0] CSR_BADV   = 14'h0007;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'h000c;

    // SAVEk sits at base plus k
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE_BASE = 14'h0030;

    localparam logic [CSR_NUM_W-1:0] CSR_TID   = 14'h0040;
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG  = 14'h0041;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL  = 14'h0042;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR = 14'h0044;

    ////////////////////
    // Exception codes

    localparam logic [ECODE_W-1:0]    ECODE_ADE     = 6'h08;
    localparam logic [ECODE_W-1:0]    ECODE_ALE     = 6'h09;
    localparam logic [ESUBCODE_W-1:0] ESUBCODE_ADEF = 9'h000;

    // Interrupt and timer constants
    localparam int TIMER_INT_BIT = 11;
    localparam int ENTRY_ALIGN   = 6;

    // Counter value of a stopped timer
    localparam logic [CSR_W-1:0] TIMER_IDLE = '1;

endpackage
